//--- src.f
+incdir+include
design/serdes_pkg.sv
design/serdes_fifo.sv
design/serdes_tx.sv
design/serdes_rx.sv
design/serdes_fc_tx.sv
design/serdes_fc_rx.sv
design/serdes.sv
tests/serdes_tb.sv

//--- run.sh
#!/bin/sh
# Verilator build and run of the serdes loopback testbench.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f src.f --top-module serdes_tb -o serdes_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/serdes_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status"
   exit 1
fi

if grep -qx "TEST RESULT: PASS" "$LOG"; then
   exit 0
fi

echo "pass message not found in $LOG"
exit 1

//--- tests/serdes_tb.sv
// serdes loopback testbench with corrupting tap, source and sink models and directed tests.
`timescale 1ns/1ps
`default_nettype none
`include "serdes_consts.svh"

module serdes_tb;
   import serdes_pkg::*;

   localparam int BP_FRAMES = 12;   // more words than the RX FIFO holds.
   localparam int BP_WORDS  = 48;

   typedef struct packed {
      logic       done;
      logic       error;
      data_word_t data;
   } sink_word_t;

   logic        clk;
   logic        reset_i = 1'b1;
   ser_sym_t    ser_tx;
   ser_sym_t    ser_rx;
   data_word_t  rd_dat  = '0;
   logic        rd_sop  = 1'b0;
   logic        rd_eop  = 1'b0;
   logic        rd_read, rd_done, rd_error;
   data_word_t  wr_dat;
   logic        wr_write, wr_done, wr_error;
   logic        wr_ready = 1'b0;
   logic        wr_full  = 1'b0;
   fifo_count_t tx_occ, rx_occ;
   logic        tx_full, tx_empty, rx_full, rx_empty, link_up;

   integer      seed = 35;
   fifo_entry_t src_q[$];           // words offered on the read side.
   int          src_idx = 0;
   sink_word_t  exp_q[$];           // expected write-side stream.
   sink_word_t  got_q[$];
   sink_word_t  mon_word;
   int          checked = 0;
   int          rd_done_cnt = 0;
   int          rd_err_cnt = 0;
   logic        rx_full_seen = 1'b0;
   logic        corrupt_on = 1'b0;
   int unsigned corrupt_idx = 0;
   int unsigned data_seen = 0;
   logic        flip;

   serdes u_dut (
      .clk(clk), .reset_i(reset_i), .ser_tx_o(ser_tx), .ser_rx_i(ser_rx),
      .rd_dat_i(rd_dat), .rd_sop_i(rd_sop), .rd_eop_i(rd_eop),
      .rd_read_o(rd_read), .rd_done_o(rd_done), .rd_error_o(rd_error),
      .wr_dat_o(wr_dat), .wr_write_o(wr_write), .wr_done_o(wr_done), .wr_error_o(wr_error),
      .wr_ready_i(wr_ready), .wr_full_i(wr_full),
      .tx_occupied_o(tx_occ), .tx_full_o(tx_full), .tx_empty_o(tx_empty),
      .rx_occupied_o(rx_occ), .rx_full_o(rx_full), .rx_empty_o(rx_empty),
      .serdes_link_up_o(link_up)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // loopback tap, source and sink
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   assign flip   = corrupt_on && !ser_tx.k_msb && !ser_tx.k_lsb && data_seen == corrupt_idx;
   assign ser_rx = ser_tx ^ {17'b0, flip};   // bit 0 is data[0].

   always @(posedge clk) begin
      if (!corrupt_on)
         data_seen <= 0;
      else if (!ser_tx.k_msb && !ser_tx.k_lsb)
         data_seen <= data_seen + 1;
   end

   // source steps to the next word after each read pulse.
   always @(posedge clk) begin
      if (rd_read)
         src_idx = src_idx + 1;
      if (src_idx < src_q.size()) begin
         rd_dat <= src_q[src_idx].data;
         rd_sop <= src_q[src_idx].sop;
         rd_eop <= src_q[src_idx].eop;
      end else begin
         rd_dat <= '0;
         rd_sop <= 1'b0;
         rd_eop <= 1'b0;
      end
   end

   always @(posedge clk) begin
      if (wr_write) begin
         mon_word.done  = wr_done;
         mon_word.error = wr_error;
         mon_word.data  = wr_dat;
         got_q.push_back(mon_word);
      end
      if (rd_done)
         rd_done_cnt <= rd_done_cnt + 1;
      if (rd_error)
         rd_err_cnt <= rd_err_cnt + 1;
      if (rx_full)
         rx_full_seen <= 1'b1;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // helpers
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic stop_with_fail();
      $display("TEST RESULT: FAIL");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("ERR %s got 0x%08h expected 0x%08h", name, got, exp);
         stop_with_fail();
      end
   endtask

   task automatic apply_reset();
      @(posedge clk);
      reset_i <= 1'b1;
      repeat (3) @(posedge clk);
      reset_i <= 1'b0;
   endtask

   task automatic set_ready(input logic value);
      @(posedge clk);
      wr_ready <= value;
   endtask

   // random payload words and their expected output if the frame is kept.
   task automatic push_frame(input int n, input bit keep);
      fifo_entry_t ent;
      sink_word_t  exp;
      for (int i = 0; i < n; i++) begin
         ent.sop  = (i == 0);
         ent.eop  = (i == n - 1);
         ent.err  = 1'b0;
         ent.data = $random(seed);
         src_q.push_back(ent);
         exp.done  = ent.eop;
         exp.error = 1'b0;
         exp.data  = ent.data;
         if (keep)
            exp_q.push_back(exp);
      end
   endtask

   task automatic wait_words(input int total, input int limit);
      int cycles = 0;
      while (got_q.size() < total) begin
         @(negedge clk);
         cycles++;
         if (cycles > limit) begin
            $display("timeout: %0d of %0d words seen on the write side", got_q.size(), total);
            stop_with_fail();
         end
      end
   endtask

   task automatic check_words();
      check_eq("wr_write_o count", got_q.size(), exp_q.size());
      for (int i = checked; i < got_q.size(); i++) begin
         check_eq($sformatf("wr_dat_o[%0d]", i), got_q[i].data, exp_q[i].data);
         check_eq($sformatf("wr_done_o[%0d]", i), got_q[i].done, exp_q[i].done);
         check_eq($sformatf("wr_error_o[%0d]", i), got_q[i].error, exp_q[i].error);
      end
      checked = got_q.size();
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // directed tests
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic run_reset_state();
      apply_reset();
      @(negedge clk);
      check_eq("rd_read_o", rd_read, 0);
      check_eq("rd_done_o", rd_done, 0);
      check_eq("rd_error_o", rd_error, 0);
      check_eq("wr_write_o", wr_write, 0);
      check_eq("wr_done_o", wr_done, 0);
      check_eq("wr_error_o", wr_error, 0);
      check_eq("serdes_link_up_o", link_up, 0);
      check_eq("inhibit_tx", u_dut.inhibit_tx, 0);
      check_eq("send_xon", u_dut.send_xon, 0);
      check_eq("send_xoff", u_dut.send_xoff, 0);
      check_eq("sent", u_dut.sent, 0);
      check_eq("tx_empty_o", tx_empty, 1);
      check_eq("rx_empty_o", rx_empty, 1);
      check_eq("tx_full_o", tx_full, 0);
      check_eq("tx_occupied_o", tx_occ, 0);
      check_eq("rx_occupied_o", rx_occ, 0);
      check_eq("ser_tx_o", ser_tx, {2'b11, `SERDES_K_IDLE});   // idles only.
   endtask

   task automatic run_link();
      int cycles = 0;
      apply_reset();
      while (!link_up) begin
         @(negedge clk);
         cycles++;
         if (cycles > `SERDES_LINK_IDLES + 10) begin
            $display("timeout: link never came up after reset");
            stop_with_fail();
         end
      end
      // not before the full run of idles has crossed the line.
      check_eq("serdes_link_up_o after idle run", cycles > `SERDES_LINK_IDLES, 1);
   endtask

   task automatic run_basic();
      int n;
      int done_before;
      n = 1 + ($unsigned($random(seed)) % `SERDES_MAX_FRAME);
      done_before = rd_done_cnt;
      push_frame(n, 1'b1);
      wait_words(exp_q.size(), 8 * n + 200);
      check_words();
      check_eq("rd_done_o count", rd_done_cnt - done_before, 1);
   endtask

   task automatic run_checksum();
      int          n;
      int          sym;
      int          base;
      sink_word_t  e;
      n    = 2 + ($unsigned($random(seed)) % (`SERDES_MAX_FRAME - 1));
      sym  = $unsigned($random(seed)) % (2 * n);   // even is a high half.
      base = exp_q.size();
      @(posedge clk);
      corrupt_idx <= sym;
      corrupt_on  <= 1'b1;
      push_frame(n, 1'b1);
      e = exp_q[base + sym / 2];
      e.data ^= (sym % 2 == 1) ? 32'h0000_0001 : 32'h0001_0000;
      exp_q[base + sym / 2] = e;
      e = exp_q[base + n - 1];
      e.done  = 1'b0;
      e.error = 1'b1;
      exp_q[base + n - 1] = e;
      wait_words(exp_q.size(), 8 * n + 200);
      @(posedge clk);
      corrupt_on <= 1'b0;
      check_words();
      run_basic();   // the frame after is clean again.
   endtask

   task automatic run_oversize();
      int cycles = 0;
      int err_before;
      int done_before;
      int seen;
      err_before  = rd_err_cnt;
      done_before = rd_done_cnt;
      seen        = got_q.size();
      push_frame(`SERDES_MAX_FRAME + 1, 1'b0);
      while (rd_err_cnt == err_before) begin
         @(negedge clk);
         cycles++;
         if (cycles > 4 * `SERDES_MAX_FRAME + 100) begin
            $display("timeout: oversized frame was never rejected");
            stop_with_fail();
         end
      end
      repeat (300) @(negedge clk);
      check_eq("rd_error_o count", rd_err_cnt - err_before, 1);
      check_eq("rd_done_o count", rd_done_cnt - done_before, 0);
      check_eq("wr_write_o count", got_q.size(), seen);
      check_eq("tx_empty_o", tx_empty, 1);
   endtask

   task automatic run_backpressure();
      int cycles = 0;
      int done_before;
      int seen;
      done_before = rd_done_cnt;
      seen        = got_q.size();
      set_ready(1'b0);
      for (int f = 0; f < BP_FRAMES; f++)
         push_frame(BP_WORDS, 1'b1);
      while (src_idx < src_q.size()) begin
         @(negedge clk);
         cycles++;
         if (cycles > 200 * BP_FRAMES) begin
            $display("timeout: source still holds words");
            stop_with_fail();
         end
      end
      repeat (600) @(negedge clk);
      check_eq("tx_empty_o", tx_empty, 0);      // xoff keeps frames back.
      check_eq("tx_full_o", tx_full, 0);
      // every word sits in one of the two FIFOs, whole frames on the TX side.
      check_eq("tx_occupied_o + rx_occupied_o", tx_occ + rx_occ, BP_FRAMES * BP_WORDS);
      check_eq("tx_occupied_o frame remainder", tx_occ % BP_WORDS, 0);
      check_eq("wr_write_o count", got_q.size(), seen);
      set_ready(1'b1);
      wait_words(exp_q.size(), 6000);
      check_eq("rx_full_o", rx_full_seen, 0);
      check_words();
      check_eq("rd_done_o count", rd_done_cnt - done_before, BP_FRAMES);
      check_eq("tx_occupied_o", tx_occ, 0);
      check_eq("rx_occupied_o", rx_occ, 0);
   endtask

   initial begin
      run_reset_state();
      run_link();
      set_ready(1'b1);
      run_basic();
      run_basic();
      run_checksum();
      run_oversize();
      run_basic();
      run_backpressure();
      repeat (200) @(negedge clk);
      check_eq("wr_write_o count", got_q.size(), exp_q.size());
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire

//--- design/serdes.sv
// serdes top level: TX, RX and both flow-control blocks.
`timescale 1ns/1ps
`default_nettype none
`include "serdes_consts.svh"

module serdes #(
   parameter int TXFIFOSIZE = 9,
   parameter int RXFIFOSIZE = 9
) (
   input  wire                        clk,
   input  wire                        reset_i,
   // line side.
   output serdes_pkg::ser_sym_t       ser_tx_o,
   input  wire serdes_pkg::ser_sym_t  ser_rx_i,
   // packet source.
   input  wire serdes_pkg::data_word_t rd_dat_i,
   input  wire                        rd_sop_i,
   input  wire                        rd_eop_i,
   output logic                       rd_read_o,
   output logic                       rd_done_o,
   output logic                       rd_error_o,
   // packet sink.
   output serdes_pkg::data_word_t     wr_dat_o,
   output logic                       wr_write_o,
   output logic                       wr_done_o,
   output logic                       wr_error_o,
   input  wire                        wr_ready_i,
   input  wire                        wr_full_i,
   // status.
   output serdes_pkg::fifo_count_t    tx_occupied_o,
   output logic                       tx_full_o,
   output logic                       tx_empty_o,
   output serdes_pkg::fifo_count_t    rx_occupied_o,
   output logic                       rx_full_o,
   output logic                       rx_empty_o,
   output logic                       serdes_link_up_o
);
   import serdes_pkg::*;

   fifo_count_t rx_space;
   logic        xon_rcvd, xoff_rcvd, inhibit_tx, send_xon, send_xoff, sent;

   serdes_tx #(.FIFOSIZE(TXFIFOSIZE)) serdes_tx (
      .clk(clk), .reset_i(reset_i),
      .rd_dat_i(rd_dat_i), .rd_sop_i(rd_sop_i), .rd_eop_i(rd_eop_i),
      .rd_read_o(rd_read_o), .rd_done_o(rd_done_o), .rd_error_o(rd_error_o),
      .inhibit_tx_i(inhibit_tx), .send_xon_i(send_xon), .send_xoff_i(send_xoff),
      .sent_o(sent), .ser_tx_o(ser_tx_o),
      .fifo_occupied_o(tx_occupied_o), .fifo_full_o(tx_full_o), .fifo_empty_o(tx_empty_o)
   );

   serdes_rx #(.FIFOSIZE(RXFIFOSIZE)) serdes_rx (
      .clk(clk), .reset_i(reset_i), .ser_rx_i(ser_rx_i),
      .wr_dat_o(wr_dat_o), .wr_write_o(wr_write_o),
      .wr_done_o(wr_done_o), .wr_error_o(wr_error_o),
      .wr_ready_i(wr_ready_i), .wr_full_i(wr_full_i),
      .xon_rcvd_o(xon_rcvd), .xoff_rcvd_o(xoff_rcvd), .rx_space_o(rx_space),
      .fifo_occupied_o(rx_occupied_o), .fifo_full_o(rx_full_o), .fifo_empty_o(rx_empty_o),
      .serdes_link_up_o(serdes_link_up_o)
   );

   // far end's xon/xoff gate our transmitter.
   serdes_fc_tx serdes_fc_tx (
      .clk(clk), .reset_i(reset_i),
      .xon_rcvd_i(xon_rcvd), .xoff_rcvd_i(xoff_rcvd), .inhibit_tx_o(inhibit_tx)
   );

   // our receive FIFO level asks the far end to hold off.
   serdes_fc_rx #(.LWMARK(`SERDES_LWMARK), .HWMARK(`SERDES_HWMARK)) serdes_fc_rx (
      .clk(clk), .reset_i(reset_i), .rx_space_i(rx_space),
      .sent_i(sent), .send_xon_o(send_xon), .send_xoff_o(send_xoff)
   );

endmodule

`default_nettype wire

//--- design/serdes_fc_rx.sv
// serdes receive flow control: watermark hysteresis and XOFF resend timer.
`timescale 1ns/1ps
`default_nettype none
`include "serdes_consts.svh"

module serdes_fc_rx #(
   parameter int LWMARK = `SERDES_LWMARK,
   parameter int HWMARK = `SERDES_HWMARK
) (
   input  wire                         clk,
   input  wire                         reset_i,
   input  wire serdes_pkg::fifo_count_t rx_space_i,
   input  wire                         sent_i,
   output logic                        send_xon_o,
   output logic                        send_xoff_o
);

   localparam int RW = $clog2(`SERDES_RESEND);

   logic          paused;      // xoff sent, no xon yet.
   logic [RW-1:0] resend_cnt;

   always_ff @(posedge clk) begin
      if (reset_i) begin
         paused      <= 1'b0;
         resend_cnt  <= '0;
         send_xon_o  <= 1'b0;
         send_xoff_o <= 1'b0;
      end else begin
         // tx sends xoff first when both are up.
         if (sent_i) begin
            if (send_xoff_o)
               send_xoff_o <= 1'b0;
            else
               send_xon_o <= 1'b0;
         end
         if (rx_space_i < LWMARK) begin
            if (!paused || resend_cnt == '0) begin
               paused      <= 1'b1;
               send_xoff_o <= 1'b1;
               send_xon_o  <= 1'b0;
               resend_cnt  <= RW'(`SERDES_RESEND - 1);
            end else begin
               resend_cnt <= resend_cnt - 1'b1;
            end
         end else if (paused && rx_space_i > HWMARK) begin
            paused     <= 1'b0;
            send_xon_o <= 1'b1;   // drained, far end may resume.
         end
      end
   end

endmodule

`default_nettype wire

//--- design/serdes_fc_tx.sv
// serdes transmit inhibit: pause timer driven by received XON/XOFF.
`timescale 1ns/1ps
`default_nettype none
`include "serdes_consts.svh"

module serdes_fc_tx (
   input  wire  clk,
   input  wire  reset_i,
   input  wire  xon_rcvd_i,
   input  wire  xoff_rcvd_i,
   output logic inhibit_tx_o
);

   localparam int PW = $clog2(`SERDES_PAUSE + 1);

   logic [PW-1:0] pause_cnt;

   always_ff @(posedge clk) begin
      if (reset_i)
         pause_cnt <= '0;
      else if (xoff_rcvd_i)
         pause_cnt <= PW'(`SERDES_PAUSE);   // each xoff restarts the pause.
      else if (xon_rcvd_i)
         pause_cnt <= '0;
      else if (pause_cnt != '0)
         pause_cnt <= pause_cnt - 1'b1;
   end

   assign inhibit_tx_o = (pause_cnt != '0);

endmodule

`default_nettype wire

//--- design/serdes_rx.sv
// serdes receive side: symbol decode, link-up, reassembly, checksum check, RX FIFO, write-out.
`timescale 1ns/1ps
`default_nettype none
`include "serdes_consts.svh"

module serdes_rx #(
   parameter int FIFOSIZE = 9
) (
   input  wire                      clk,
   input  wire                      reset_i,
   input  wire serdes_pkg::ser_sym_t ser_rx_i,
   output serdes_pkg::data_word_t   wr_dat_o,
   output logic                     wr_write_o,
   output logic                     wr_done_o,
   output logic                     wr_error_o,
   input  wire                      wr_ready_i,
   input  wire                      wr_full_i,
   output logic                     xon_rcvd_o,
   output logic                     xoff_rcvd_o,
   output serdes_pkg::fifo_count_t  rx_space_o,
   output serdes_pkg::fifo_count_t  fifo_occupied_o,
   output logic                     fifo_full_o,
   output logic                     fifo_empty_o,
   output logic                     serdes_link_up_o
);
   import serdes_pkg::*;

   localparam int LW = $clog2(`SERDES_LINK_IDLES + 1);

   ser_sym_t      sym_q;
   logic          is_data, is_idle, is_sof, is_eof, is_xon, is_xoff, is_unknown;
   logic [LW-1:0] idle_cnt;
   rx_state_e     state;
   ser_word_t     hi_q;        // high half, or the checksum once eof shows up.
   csum_t         csum;
   data_word_t    pend_data;   // last whole word, held until we know if it ends the frame.
   logic          pend_valid;
   logic          pend_sop;
   logic          err_q;
   logic          fifo_wr;
   fifo_entry_t   wr_entry;
   fifo_entry_t   head;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // decode and link-up
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   assign is_data    = !sym_q.k_msb && !sym_q.k_lsb;
   assign is_idle    = sym_q.k_msb && sym_q.k_lsb && sym_q.data == `SERDES_K_IDLE;
   assign is_sof     = sym_q.k_msb && sym_q.k_lsb && sym_q.data == `SERDES_K_SOF;
   assign is_eof     = sym_q.k_msb && sym_q.k_lsb && sym_q.data == `SERDES_K_EOF;
   assign is_xon     = sym_q.k_msb && sym_q.k_lsb && sym_q.data == `SERDES_K_XON;
   assign is_xoff    = sym_q.k_msb && sym_q.k_lsb && sym_q.data == `SERDES_K_XOFF;
   assign is_unknown = !is_data && !(is_idle || is_sof || is_eof || is_xon || is_xoff);

   always_ff @(posedge clk) begin
      if (reset_i) begin
         sym_q            <= '0;
         idle_cnt         <= '0;
         serdes_link_up_o <= 1'b0;
         xon_rcvd_o       <= 1'b0;
         xoff_rcvd_o      <= 1'b0;
      end else begin
         sym_q       <= ser_rx_i;
         xon_rcvd_o  <= is_xon;
         xoff_rcvd_o <= is_xoff;
         if (is_idle) begin
            if (idle_cnt != `SERDES_LINK_IDLES)
               idle_cnt <= idle_cnt + 1'b1;
            if (idle_cnt == `SERDES_LINK_IDLES - 1)
               serdes_link_up_o <= 1'b1;
         end else begin
            idle_cnt <= '0;
            if (is_unknown)
               serdes_link_up_o <= 1'b0;   // garbage on the line.
         end
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // reassembly
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk) begin
      if (reset_i) begin
         state      <= RX_WAIT_SOF;
         pend_valid <= 1'b0;
         fifo_wr    <= 1'b0;
      end else begin
         fifo_wr <= 1'b0;
         case (state)
            RX_WAIT_SOF: begin
               csum <= '0;
               if (is_sof)
                  state <= RX_HI;
            end
            RX_HI: begin
               if (is_data) begin
                  hi_q  <= sym_q.data;
                  state <= RX_LO;
               end else begin
                  err_q <= 1'b1;      // frame cut short.
                  state <= RX_CSUM_CHK;
               end
            end
            RX_LO: begin
               if (is_data) begin
                  csum       <= csum + hi_q + sym_q.data;
                  pend_data  <= {hi_q, sym_q.data};
                  pend_valid <= 1'b1;
                  pend_sop   <= !pend_valid;
                  // the previous word is now known not to be the last.
                  fifo_wr  <= pend_valid;
                  wr_entry <= '{sop: pend_sop, eop: 1'b0, err: 1'b0, data: pend_data};
                  state    <= RX_HI;
               end else begin
                  err_q <= !(is_eof && csum == hi_q);
                  state <= RX_CSUM_CHK;
               end
            end
            RX_CSUM_CHK: begin
               fifo_wr    <= pend_valid;
               wr_entry   <= '{sop: pend_sop, eop: 1'b1, err: err_q, data: pend_data};
               pend_valid <= 1'b0;
               state      <= RX_WAIT_SOF;  // tx always puts an idle after eof.
            end
            default: state <= RX_WAIT_SOF;
         endcase
      end
   end

   serdes_fifo #(.DEPTH_LOG2(FIFOSIZE)) rx_fifo (
      .clk       (clk),
      .reset_i   (reset_i),
      .wr_en_i   (fifo_wr && !fifo_full_o),
      .wr_data_i (wr_entry),
      .rewind_i  (1'b0),
      .rd_en_i   (wr_write_o),
      .rd_data_o (head),
      .occupied_o(fifo_occupied_o),
      .space_o   (rx_space_o),
      .full_o    (fifo_full_o),
      .empty_o   (fifo_empty_o)
   );

   // write-out to the sink.
   assign wr_write_o = !fifo_empty_o && wr_ready_i && !wr_full_i;
   assign wr_dat_o   = head.data;
   assign wr_done_o  = wr_write_o && head.eop && !head.err;
   assign wr_error_o = wr_write_o && head.eop && head.err;

endmodule

`default_nettype wire

//--- design/serdes_tx.sv
// serdes transmit side: packet intake, TX FIFO, framer with checksum, XON/XOFF insertion.
`timescale 1ns/1ps
`default_nettype none
`include "serdes_consts.svh"

module serdes_tx #(
   parameter int FIFOSIZE = 9
) (
   input  wire                        clk,
   input  wire                        reset_i,
   input  wire serdes_pkg::data_word_t rd_dat_i,
   input  wire                        rd_sop_i,
   input  wire                        rd_eop_i,
   output logic                       rd_read_o,
   output logic                       rd_done_o,
   output logic                       rd_error_o,
   input  wire                        inhibit_tx_i,
   input  wire                        send_xon_i,
   input  wire                        send_xoff_i,
   output logic                       sent_o,
   output serdes_pkg::ser_sym_t       ser_tx_o,
   output serdes_pkg::fifo_count_t    fifo_occupied_o,
   output logic                       fifo_full_o,
   output logic                       fifo_empty_o
);
   import serdes_pkg::*;

   localparam int LW = $clog2(`SERDES_MAX_FRAME + 1);

   logic          in_frame;
   logic          drop;        // rest of this frame is thrown away.
   logic          word_bad;
   logic          fifo_wr;
   logic          fifo_rd;
   logic [LW-1:0] frame_len;
   fifo_count_t   frames;      // complete frames waiting in the FIFO.
   fifo_entry_t   in_entry;
   fifo_entry_t   head;
   tx_state_e     state;
   csum_t         csum;

   function automatic ser_sym_t k_sym(input ser_word_t code);
      return '{k_msb: 1'b1, k_lsb: 1'b1, data: code};
   endfunction

   function automatic ser_sym_t d_sym(input ser_word_t word);
      return '{k_msb: 1'b0, k_lsb: 1'b0, data: word};
   endfunction

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // intake
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   assign word_bad   = !rd_sop_i && (drop || !in_frame || frame_len >= `SERDES_MAX_FRAME);
   assign fifo_wr    = rd_read_o && !word_bad;
   assign rd_done_o  = fifo_wr && rd_eop_i;
   assign rd_error_o = rd_read_o && rd_eop_i && word_bad;
   assign in_entry   = '{sop: rd_sop_i, eop: rd_eop_i, err: 1'b0, data: rd_dat_i};

   always_ff @(posedge clk) begin
      if (reset_i) begin
         rd_read_o <= 1'b0;
         in_frame  <= 1'b0;
         drop      <= 1'b0;
         frame_len <= '0;
      end else begin
         // one take every other cycle, the source steps after each pulse.
         rd_read_o <= !rd_read_o && (rd_sop_i || rd_eop_i || in_frame)
                      && (!fifo_full_o || drop);
         if (rd_read_o) begin
            in_frame <= !rd_eop_i;
            drop     <= word_bad && !rd_eop_i;
            if (rd_sop_i)
               frame_len <= LW'(1);
            else if (frame_len < `SERDES_MAX_FRAME)
               frame_len <= frame_len + 1'b1;   // saturates, next word is too many.
         end
      end
   end

   serdes_fifo #(.DEPTH_LOG2(FIFOSIZE)) tx_fifo (
      .clk       (clk),
      .reset_i   (reset_i),
      .wr_en_i   (fifo_wr),
      .wr_data_i (in_entry),
      .rewind_i  (rd_error_o),
      .rd_en_i   (fifo_rd),
      .rd_data_o (head),
      .occupied_o(fifo_occupied_o),
      .space_o   (),
      .full_o    (fifo_full_o),
      .empty_o   (fifo_empty_o)
   );

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // framer
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   assign fifo_rd = (state == TX_LO);   // word leaves with its low half.

   always_ff @(posedge clk) begin
      if (reset_i) begin
         state    <= TX_IDLE;
         ser_tx_o <= k_sym(`SERDES_K_IDLE);
         sent_o   <= 1'b0;
         csum     <= '0;
         frames   <= '0;
      end else begin
         sent_o <= 1'b0;
         frames <= frames + fifo_count_t'(fifo_wr && rd_eop_i)
                   - fifo_count_t'(fifo_rd && head.eop);
         case (state)
            TX_IDLE: begin
               ser_tx_o <= k_sym(`SERDES_K_IDLE);
               // request stays up one cycle past sent, so skip that cycle.
               if ((send_xon_i || send_xoff_i) && !sent_o)
                  state <= TX_FC;
               else if (frames != '0 && !inhibit_tx_i)
                  state <= TX_SOF;
            end
            TX_SOF: begin
               ser_tx_o <= k_sym(`SERDES_K_SOF);
               csum     <= '0;
               state    <= TX_HI;
            end
            TX_HI: begin
               ser_tx_o <= d_sym(head.data[31:16]);
               csum     <= csum + head.data[31:16];
               state    <= TX_LO;
            end
            TX_LO: begin
               ser_tx_o <= d_sym(head.data[15:0]);
               csum     <= csum + head.data[15:0];
               state    <= head.eop ? TX_CSUM : TX_HI;
            end
            TX_CSUM: begin
               ser_tx_o <= d_sym(csum);
               state    <= TX_EOF;
            end
            TX_EOF: begin
               ser_tx_o <= k_sym(`SERDES_K_EOF);
               state    <= TX_IDLE;
            end
            TX_FC: begin
               ser_tx_o <= k_sym(send_xoff_i ? `SERDES_K_XOFF : `SERDES_K_XON);  // xoff wins.
               sent_o   <= 1'b1;
               state    <= TX_IDLE;
            end
            default: state <= TX_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- design/serdes_fifo.sv
// synchronous first-word fall-through FIFO with frame rewind and fill levels.
`timescale 1ns/1ps
`default_nettype none

module serdes_fifo #(
   parameter int DEPTH_LOG2 = 9
) (
   input  wire                         clk,
   input  wire                         reset_i,
   input  wire                         wr_en_i,
   input  wire serdes_pkg::fifo_entry_t wr_data_i,
   input  wire                         rewind_i,
   input  wire                         rd_en_i,
   output serdes_pkg::fifo_entry_t     rd_data_o,
   output serdes_pkg::fifo_count_t     occupied_o,
   output serdes_pkg::fifo_count_t     space_o,
   output logic                        full_o,
   output logic                        empty_o
);
   import serdes_pkg::*;

   localparam int DEPTH = 1 << DEPTH_LOG2;

   typedef logic [DEPTH_LOG2:0] ptr_t;  // one extra bit tells full from empty.

   fifo_entry_t mem [DEPTH];
   ptr_t        wr_ptr;
   ptr_t        rd_ptr;
   ptr_t        mark_ptr;               // write position after the last eop.
   ptr_t        used;

   always_ff @(posedge clk) begin
      if (wr_en_i)
         mem[wr_ptr[DEPTH_LOG2-1:0]] <= wr_data_i;
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         mark_ptr <= '0;
      end else begin
         if (rewind_i) begin
            wr_ptr <= mark_ptr;       // drop the partial frame.
         end else if (wr_en_i) begin
            wr_ptr <= wr_ptr + 1'b1;
            if (wr_data_i.eop)
               mark_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en_i)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   assign used       = wr_ptr - rd_ptr;
   assign rd_data_o  = mem[rd_ptr[DEPTH_LOG2-1:0]];
   assign occupied_o = fifo_count_t'(used);
   assign space_o    = fifo_count_t'(DEPTH) - occupied_o;
   assign full_o     = (used == ptr_t'(DEPTH));
   assign empty_o    = (used == '0);

endmodule

`default_nettype wire

//--- design/serdes_pkg.sv
// serdes width typedefs, symbol and FIFO entry structs, TX and RX state enums.
`default_nettype none

package serdes_pkg;

   typedef logic [15:0] ser_word_t;
   typedef logic [31:0] data_word_t;
   typedef logic [15:0] fifo_count_t;
   typedef logic [15:0] csum_t;

   // one line symbol with its two K flags.
   typedef struct packed {
      logic      k_msb;
      logic      k_lsb;
      ser_word_t data;
   } ser_sym_t;

   typedef struct packed {
      logic       sop;
      logic       eop;
      logic       err;    // bad checksum, set on the eop entry only.
      data_word_t data;
   } fifo_entry_t;

   typedef enum logic [2:0] {
      TX_IDLE, TX_SOF, TX_HI, TX_LO, TX_CSUM, TX_EOF, TX_FC
   } tx_state_e;

   typedef enum logic [1:0] {
      RX_WAIT_SOF, RX_HI, RX_LO, RX_CSUM_CHK
   } rx_state_e;

endpackage

`default_nettype wire

//--- include/serdes_consts.svh
// serdes K codes, flow-control watermarks, frame limit and timer lengths.
`ifndef SERDES_CONSTS_SVH
`define SERDES_CONSTS_SVH

// K symbols, always sent with both K flags set.
`define SERDES_K_IDLE     16'hBCBC
`define SERDES_K_SOF      16'h5C5C
`define SERDES_K_EOF      16'hFDFD
`define SERDES_K_XON      16'h1C1C
`define SERDES_K_XOFF     16'h3C3C

// receive FIFO space thresholds, in words.
`define SERDES_LWMARK     96     // below this, ask the far end to stop.
`define SERDES_HWMARK     256    // above this, let it go again.

`define SERDES_MAX_FRAME  64     // payload words, must stay below LWMARK.
`define SERDES_LINK_IDLES 16

// timers, in clock cycles.
`define SERDES_PAUSE      1024
`define SERDES_RESEND     256

`endif
